//--- nx_pkg.sv
// Shared widths, field positions, command and direction codes, payload union, routing function
`default_nettype none

package nx_pkg;

// ------------------------------
// Widths
// ------------------------------

localparam int NX_ROW_W     = 4;
localparam int NX_COL_W     = 4;
localparam int NX_CMD_W     = 2;
localparam int NX_MSG_W     = 32;
localparam int NX_PAYLOAD_W = NX_MSG_W - NX_ROW_W - NX_COL_W - NX_CMD_W;
localparam int NX_INPUTS    = 4;
localparam int NX_LUT_W     = 1 << NX_INPUTS;
localparam int NX_IDX_W     = $clog2(NX_INPUTS);

// Field positions within one message word
localparam int NX_ROW_MSB = NX_MSG_W - 1;
localparam int NX_ROW_LSB = NX_ROW_MSB - NX_ROW_W + 1;
localparam int NX_COL_MSB = NX_ROW_LSB - 1;
localparam int NX_COL_LSB = NX_COL_MSB - NX_COL_W + 1;
localparam int NX_CMD_MSB = NX_COL_LSB - 1;
localparam int NX_CMD_LSB = NX_CMD_MSB - NX_CMD_W + 1;
localparam int NX_PAY_MSB = NX_CMD_LSB - 1;
localparam int NX_PAY_LSB = 0;

// ------------------------------
// Codes
// ------------------------------

// Code 3 is reserved, logic unit drops it
typedef enum logic [NX_CMD_W-1:0] {
      NX_CMD_SIGNAL = 2'd0
    , NX_CMD_LUT    = 2'd1
    , NX_CMD_MAP    = 2'd2
} nx_cmd_e;

typedef enum logic [1:0] {
      NX_DIR_NORTH = 2'd0
    , NX_DIR_EAST  = 2'd1
    , NX_DIR_SOUTH = 2'd2
    , NX_DIR_WEST  = 2'd3
} nx_dir_e;

// ------------------------------
// Payload views
// ------------------------------

// Signal update, index and state in the top bits
typedef struct packed {
    logic [NX_IDX_W-1:0]              index;
    logic                             state;
    logic [NX_PAYLOAD_W-NX_IDX_W-2:0] pad;
} nx_sig_view_t;

// Truth table load, entry N is output for input pattern N
typedef struct packed {
    logic [NX_LUT_W-1:0]              truth;
    logic [NX_PAYLOAD_W-NX_LUT_W-1:0] pad;
} nx_lut_view_t;

// Output mapping, where the node output is sent
typedef struct packed {
    logic [NX_ROW_W-1:0]                                 row;
    logic [NX_COL_W-1:0]                                 col;
    logic [NX_IDX_W-1:0]                                 index;
    logic [NX_PAYLOAD_W-NX_ROW_W-NX_COL_W-NX_IDX_W-1:0] pad;
} nx_map_view_t;

// Chosen by the command field
typedef union packed {
    nx_sig_view_t sig;
    nx_lut_view_t lut;
    nx_map_view_t map;
} nx_payload_u;

// Rows first, then columns
function automatic nx_dir_e nx_route_dir(
    input logic [NX_ROW_W-1:0] node_row,
    input logic [NX_COL_W-1:0] node_col,
    input logic [NX_ROW_W-1:0] tgt_row,
    input logic [NX_COL_W-1:0] tgt_col
);
    if (tgt_row > node_row) return NX_DIR_SOUTH;
    if (tgt_row < node_row) return NX_DIR_NORTH;
    if (tgt_col > node_col) return NX_DIR_EAST;
    return NX_DIR_WEST;
endfunction

endpackage : nx_pkg

`default_nettype wire

//--- nx_msg_router.sv
// Inbound router: address compare, local path register, bypass path register with direction
`timescale 1ns/100ps
`default_nettype none

module nx_msg_router
    import nx_pkg::*;
(
      input  logic                clk_i
    , input  logic                rst_n_i
    // Node address
    , input  logic [NX_ROW_W-1:0] node_row_i
    , input  logic [NX_COL_W-1:0] node_col_i
    // Inbound stream
    , input  logic [NX_MSG_W-1:0] ib_data_i
    , input  logic                ib_valid_i
    , output logic                ib_ready_o
    // Local stream to logic unit
    , output logic [NX_MSG_W-1:0] loc_data_o
    , output logic                loc_valid_o
    , input  logic                loc_ready_i
    // Bypass stream to combiner
    , output logic [NX_MSG_W-1:0] byp_data_o
    , output nx_dir_e             byp_dir_o
    , output logic                byp_valid_o
    , input  logic                byp_ready_i
    // Both registers empty
    , output logic                idle_o
);

// ------------------------------
// Address decode
// ------------------------------

logic [NX_ROW_W-1:0] tgt_row;
logic [NX_COL_W-1:0] tgt_col;
logic                is_local;
logic                ib_accept;
logic                loc_load, byp_load;

logic [NX_MSG_W-1:0] loc_data_q, byp_data_q;
nx_dir_e             byp_dir_q;
logic                loc_valid_q, byp_valid_q;

assign tgt_row  = ib_data_i[NX_ROW_MSB:NX_ROW_LSB];
assign tgt_col  = ib_data_i[NX_COL_MSB:NX_COL_LSB];
assign is_local = (tgt_row == node_row_i) && (tgt_col == node_col_i);

// Ready only looks at the register this message heads for
assign ib_ready_o = is_local ? (!loc_valid_q || loc_ready_i)
                             : (!byp_valid_q || byp_ready_i);

assign ib_accept = ib_valid_i && ib_ready_o;
assign loc_load  = ib_accept && is_local;
assign byp_load  = ib_accept && !is_local;

// ------------------------------
// Path registers
// ------------------------------

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        loc_valid_q <= 1'b0;
        byp_valid_q <= 1'b0;
    end else begin
        // Load wins over drain in the same cycle
        if (loc_load) begin
            loc_valid_q <= 1'b1;
        end else if (loc_ready_i) begin
            loc_valid_q <= 1'b0;
        end
        if (byp_load) begin
            byp_valid_q <= 1'b1;
        end else if (byp_ready_i) begin
            byp_valid_q <= 1'b0;
        end
    end
end

// Payload, direction worked out once on entry
always_ff @(posedge clk_i) begin
    if (loc_load) begin
        loc_data_q <= ib_data_i;
    end
    if (byp_load) begin
        byp_data_q <= ib_data_i;
        byp_dir_q  <= nx_route_dir(node_row_i, node_col_i, tgt_row, tgt_col);
    end
end

assign loc_data_o  = loc_data_q;
assign loc_valid_o = loc_valid_q;
assign byp_data_o  = byp_data_q;
assign byp_dir_o   = byp_dir_q;
assign byp_valid_o = byp_valid_q;

assign idle_o = !loc_valid_q && !byp_valid_q;

// One accepted message shows up on one path only
a_one_path: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ib_accept |=> !($rose(loc_valid_q) && $rose(byp_valid_q)));

endmodule : nx_msg_router

`default_nettype wire

//--- nx_logic_unit.sv
// Logic unit: local command decode, input bits, truth table, output map, emit register
`timescale 1ns/100ps
`default_nettype none

module nx_logic_unit
    import nx_pkg::*;
(
      input  logic                clk_i
    , input  logic                rst_n_i
    // Node address
    , input  logic [NX_ROW_W-1:0] node_row_i
    , input  logic [NX_COL_W-1:0] node_col_i
    // Local stream from router
    , input  logic [NX_MSG_W-1:0] loc_data_i
    , input  logic                loc_valid_i
    , output logic                loc_ready_o
    // Emit stream to combiner
    , output logic [NX_MSG_W-1:0] emit_data_o
    , output nx_dir_e             emit_dir_o
    , output logic                emit_valid_o
    , input  logic                emit_ready_i
    // Nothing waiting to leave
    , output logic                idle_o
);

// ------------------------------
// Decode
// ------------------------------

nx_cmd_e              loc_cmd;
nx_payload_u          loc_payload;
logic                 loc_accept;

logic [NX_INPUTS-1:0] inputs_q, inputs_nxt;
logic [NX_LUT_W-1:0]  lut_q, lut_nxt;
logic [NX_ROW_W-1:0]  map_row_q;
logic [NX_COL_W-1:0]  map_col_q;
logic [NX_IDX_W-1:0]  map_idx_q;
logic                 map_valid_q;
logic                 last_q;

logic                 evaluate, eval_bit, emit_load;
nx_payload_u          emit_payload;
logic [NX_MSG_W-1:0]  emit_data_q;
nx_dir_e              emit_dir_q;
logic                 emit_valid_q;

assign loc_cmd     = nx_cmd_e'(loc_data_i[NX_CMD_MSB:NX_CMD_LSB]);
assign loc_payload = loc_data_i[NX_PAY_MSB:NX_PAY_LSB];

// Stall only while a pending emit is stuck
assign loc_ready_o = !emit_valid_q || emit_ready_i;
assign loc_accept  = loc_valid_i && loc_ready_o;

// Next inputs and table as seen after this message
always_comb begin
    inputs_nxt = inputs_q;
    lut_nxt    = lut_q;
    evaluate   = 1'b0;
    case (loc_cmd)
        NX_CMD_SIGNAL: begin
            inputs_nxt[loc_payload.sig.index] = loc_payload.sig.state;
            evaluate                          = 1'b1;
        end
        NX_CMD_LUT: begin
            lut_nxt  = loc_payload.lut.truth;
            evaluate = 1'b1;
        end
        // Map and reserved never trigger evaluation
        default: begin
            evaluate = 1'b0;
        end
    endcase
end

// Table lookup on the updated state
assign eval_bit  = lut_nxt[inputs_nxt];
assign emit_load = loc_accept && evaluate && map_valid_q && (eval_bit != last_q);

// ------------------------------
// State
// ------------------------------

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        inputs_q    <= '0;
        lut_q       <= '0;
        map_row_q   <= '0;
        map_col_q   <= '0;
        map_idx_q   <= '0;
        map_valid_q <= 1'b0;
        last_q      <= 1'b0;
    end else if (loc_accept) begin
        inputs_q <= inputs_nxt;
        lut_q    <= lut_nxt;
        if (loc_cmd == NX_CMD_MAP) begin
            map_row_q   <= loc_payload.map.row;
            map_col_q   <= loc_payload.map.col;
            map_idx_q   <= loc_payload.map.index;
            map_valid_q <= 1'b1;
        end
        // Only track what actually went out
        if (emit_load) begin
            last_q <= eval_bit;
        end
    end
end

// ------------------------------
// Emit register
// ------------------------------

// Signal update for the mapped input of the target
always_comb begin
    emit_payload           = '0;
    emit_payload.sig.index = map_idx_q;
    emit_payload.sig.state = eval_bit;
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        emit_valid_q <= 1'b0;
    end else if (emit_load) begin
        emit_valid_q <= 1'b1;
    end else if (emit_ready_i) begin
        emit_valid_q <= 1'b0;
    end
end

always_ff @(posedge clk_i) begin
    if (emit_load) begin
        emit_data_q <= {map_row_q, map_col_q, NX_CMD_SIGNAL, emit_payload};
        emit_dir_q  <= nx_route_dir(node_row_i, node_col_i, map_row_q, map_col_q);
    end
end

assign emit_data_o  = emit_data_q;
assign emit_dir_o   = emit_dir_q;
assign emit_valid_o = emit_valid_q;

assign idle_o = !emit_valid_q;

// A stalled emit is never overwritten
a_emit_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (emit_valid_q && !emit_ready_i) |=>
        (emit_valid_q && $stable(emit_data_q) && $stable(emit_dir_q)));

endmodule : nx_logic_unit

`default_nettype wire

//--- nx_stream_combiner.sv
// Stream combiner: one registered output, bypass stream preferred over emit stream
`timescale 1ns/100ps
`default_nettype none

module nx_stream_combiner
    import nx_pkg::*;
(
      input  logic                clk_i
    , input  logic                rst_n_i
    // Bypass stream, higher priority
    , input  logic [NX_MSG_W-1:0] byp_data_i
    , input  nx_dir_e             byp_dir_i
    , input  logic                byp_valid_i
    , output logic                byp_ready_o
    // Emit stream
    , input  logic [NX_MSG_W-1:0] emit_data_i
    , input  nx_dir_e             emit_dir_i
    , input  logic                emit_valid_i
    , output logic                emit_ready_o
    // Outbound stream
    , output logic [NX_MSG_W-1:0] ob_data_o
    , output nx_dir_e             ob_dir_o
    , output logic                ob_valid_o
    , input  logic                ob_ready_i
    // Output register empty
    , output logic                idle_o
);

logic                can_load;
logic                take_byp, take_emit;
logic [NX_MSG_W-1:0] ob_data_q;
nx_dir_e             ob_dir_q;
logic                ob_valid_q;

// ------------------------------
// Selection
// ------------------------------

// Free or emptying this cycle
assign can_load = !ob_valid_q || ob_ready_i;

// Emit waits whenever bypass has something
assign byp_ready_o  = can_load;
assign emit_ready_o = can_load && !byp_valid_i;

assign take_byp  = byp_valid_i && byp_ready_o;
assign take_emit = emit_valid_i && emit_ready_o;

// ------------------------------
// Output register
// ------------------------------

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        ob_valid_q <= 1'b0;
    end else if (take_byp || take_emit) begin
        ob_valid_q <= 1'b1;
    end else if (ob_ready_i) begin
        ob_valid_q <= 1'b0;
    end
end

always_ff @(posedge clk_i) begin
    if (take_byp) begin
        ob_data_q <= byp_data_i;
        ob_dir_q  <= byp_dir_i;
    end else if (take_emit) begin
        ob_data_q <= emit_data_i;
        ob_dir_q  <= emit_dir_i;
    end
end

assign ob_data_o  = ob_data_q;
assign ob_dir_o   = ob_dir_q;
assign ob_valid_o = ob_valid_q;

assign idle_o = !ob_valid_q;

// Outbound word held under back-pressure
a_ob_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ob_valid_o && !ob_ready_i) |=>
        (ob_valid_o && $stable(ob_data_o) && $stable(ob_dir_o)));

endmodule : nx_stream_combiner

`default_nettype wire

//--- nx_node.sv
// Node top: router and logic unit side by side, combiner on the outbound stream, idle flag
`timescale 1ns/100ps
`default_nettype none

module nx_node
    import nx_pkg::*;
(
      input  logic                clk_i
    , input  logic                rst_n_i
    // Static node address
    , input  logic [NX_ROW_W-1:0] node_row_i
    , input  logic [NX_COL_W-1:0] node_col_i
    // Inbound stream
    , input  logic [NX_MSG_W-1:0] ib_data_i
    , input  logic                ib_valid_i
    , output logic                ib_ready_o
    // Outbound stream
    , output logic [NX_MSG_W-1:0] ob_data_o
    , output nx_dir_e             ob_dir_o
    , output logic                ob_valid_o
    , input  logic                ob_ready_i
    // All parts drained
    , output logic                idle_o
);

// ------------------------------
// Router
// ------------------------------

logic [NX_MSG_W-1:0] loc_data, byp_data, emit_data;
logic                loc_valid, loc_ready;
nx_dir_e             byp_dir, emit_dir;
logic                byp_valid, byp_ready;
logic                emit_valid, emit_ready;
logic                rtr_idle, lgc_idle, cmb_idle;
logic                idle_q;

nx_msg_router router (
      .clk_i      (clk_i     )
    , .rst_n_i    (rst_n_i   )
    , .node_row_i (node_row_i)
    , .node_col_i (node_col_i)
    , .ib_data_i  (ib_data_i )
    , .ib_valid_i (ib_valid_i)
    , .ib_ready_o (ib_ready_o)
    , .loc_data_o (loc_data  )
    , .loc_valid_o(loc_valid )
    , .loc_ready_i(loc_ready )
    , .byp_data_o (byp_data  )
    , .byp_dir_o  (byp_dir   )
    , .byp_valid_o(byp_valid )
    , .byp_ready_i(byp_ready )
    , .idle_o     (rtr_idle  )
);

// ------------------------------
// Logic unit
// ------------------------------

nx_logic_unit logic_unit (
      .clk_i       (clk_i     )
    , .rst_n_i     (rst_n_i   )
    , .node_row_i  (node_row_i)
    , .node_col_i  (node_col_i)
    , .loc_data_i  (loc_data  )
    , .loc_valid_i (loc_valid )
    , .loc_ready_o (loc_ready )
    , .emit_data_o (emit_data )
    , .emit_dir_o  (emit_dir  )
    , .emit_valid_o(emit_valid)
    , .emit_ready_i(emit_ready)
    , .idle_o      (lgc_idle  )
);

// ------------------------------
// Combiner
// ------------------------------

nx_stream_combiner combiner (
      .clk_i       (clk_i     )
    , .rst_n_i     (rst_n_i   )
    , .byp_data_i  (byp_data  )
    , .byp_dir_i   (byp_dir   )
    , .byp_valid_i (byp_valid )
    , .byp_ready_o (byp_ready )
    , .emit_data_i (emit_data )
    , .emit_dir_i  (emit_dir  )
    , .emit_valid_i(emit_valid)
    , .emit_ready_o(emit_ready)
    , .ob_data_o   (ob_data_o )
    , .ob_dir_o    (ob_dir_o  )
    , .ob_valid_o  (ob_valid_o)
    , .ob_ready_i  (ob_ready_i)
    , .idle_o      (cmb_idle  )
);

// Low for the first cycle out of reset
always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        idle_q <= 1'b0;
    end else begin
        idle_q <= rtr_idle && lgc_idle && cmb_idle;
    end
end

assign idle_o = idle_q;

endmodule : nx_node

`default_nettype wire

//--- tb_clock_gen.sv
// Testbench clock source and power-on reset pulse
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
      output logic clk_o
    , output logic rst_n_o
);

// 100 ns period
initial begin
    clk_o = 1'b0;
    forever #50 clk_o = !clk_o;
end

// Reset held low for three rising edges
initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;
end

endmodule : tb_clock_gen

`default_nettype wire

//--- tb_nx_node.sv
// Stimulus tasks, reference model, output checker, timeout and summary for the node
`timescale 1ns/100ps
`default_nettype none

module tb_nx_node;

// Messages per test in order bypass, no_map, logic_eval, backpressure, latency
localparam int NUM_MSGS    = 40 + 11 + 41 + 40 + 3;
localparam int CYCLE_LIMIT = 40 * NUM_MSGS + 200;
localparam logic [3:0] MY_ROW = 4'd5;
localparam logic [3:0] MY_COL = 4'd5;
localparam logic [3:0] MT_ROW = 4'd2;
localparam logic [3:0] MT_COL = 4'd9;

logic        clk_i, rst_n_i;
logic [31:0] ib_data_i;
logic        ib_valid_i, ib_ready_o;
logic [31:0] ob_data_o;
logic [1:0]  ob_dir_o;
logic        ob_valid_o, ob_ready_i;
logic        idle_o;
logic        bp_mode;
logic [31:0] bp_word;

// Model state
logic [3:0]  m_inp;
logic [15:0] m_lut;
logic [3:0]  m_row, m_col;
logic [1:0]  m_idx;
logic        m_mval, m_last;

logic [31:0] byp_q[$];
logic [31:0] emit_q[$];
logic [1:0]  byp_dir_q[$];
logic [1:0]  emit_dir_q[$];
logic [31:0] rng;
int          errors, checks, tests, ob_count, sent, cycles;

tb_clock_gen clk_gen (.clk_o(clk_i), .rst_n_o(rst_n_i));

nx_node dut0 (
      .clk_i      (clk_i     )
    , .rst_n_i    (rst_n_i   )
    , .node_row_i (MY_ROW    )
    , .node_col_i (MY_COL    )
    , .ib_data_i  (ib_data_i )
    , .ib_valid_i (ib_valid_i)
    , .ib_ready_o (ib_ready_o)
    , .ob_data_o  (ob_data_o )
    , .ob_dir_o   (ob_dir_o  )
    , .ob_valid_o (ob_valid_o)
    , .ob_ready_i (ob_ready_i)
    , .idle_o     (idle_o    )
);

// ------------------------------
// Reference helpers
// ------------------------------

function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
endfunction

// Row picks north or south before column picks east or west
function automatic logic [1:0] expect_dir(input logic [3:0] row, input logic [3:0] col);
    if (row > MY_ROW) return 2'd2;
    if (row < MY_ROW) return 2'd0;
    if (col > MY_COL) return 2'd1;
    return 2'd3;
endfunction

// One local message against the model state
function automatic void nx_model(
      input  logic [31:0] msg
    , inout  logic [3:0]  inp
    , inout  logic [15:0] lut
    , inout  logic [3:0]  mrow
    , inout  logic [3:0]  mcol
    , inout  logic [1:0]  midx
    , inout  logic        mval
    , inout  logic        last
    , output logic        emit
    , output logic [31:0] edata
    , output logic [1:0]  edir
);
    logic [1:0] cmd;
    logic       eval_en;
    logic       out_bit;
    cmd     = msg[23:22];
    eval_en = 1'b0;
    emit    = 1'b0;
    edata   = '0;
    edir    = '0;
    if (cmd == 2'd0) begin
        inp[msg[21:20]] = msg[19];
        eval_en         = 1'b1;
    end else if (cmd == 2'd1) begin
        lut     = msg[21:6];
        eval_en = 1'b1;
    end else if (cmd == 2'd2) begin
        mrow = msg[21:18];
        mcol = msg[17:14];
        midx = msg[13:12];
        mval = 1'b1;
    end
    out_bit = lut[inp];
    if (eval_en && mval && out_bit != last) begin
        emit  = 1'b1;
        edata = {mrow, mcol, 2'b00, midx, out_bit, 19'd0};
        edir  = expect_dir(mrow, mcol);
        last  = out_bit;
    end
endfunction

// ------------------------------
// Stimulus tasks
// ------------------------------

task automatic send_msg(input logic [31:0] msg);
    logic        emit;
    logic [31:0] edata;
    logic [1:0]  edir;
    if (msg[31:24] == {MY_ROW, MY_COL}) begin
        nx_model(msg, m_inp, m_lut, m_row, m_col, m_idx, m_mval, m_last, emit, edata, edir);
        if (emit) begin
            emit_q.push_back(edata);
            emit_dir_q.push_back(edir);
        end
    end else begin
        byp_q.push_back(msg);
        byp_dir_q.push_back(expect_dir(msg[31:28], msg[27:24]));
    end
    sent++;
    @(posedge clk_i);
    ib_data_i  <= msg;
    ib_valid_i <= 1'b1;
    do @(negedge clk_i); while (!ib_ready_o);
    @(posedge clk_i);
    ib_valid_i <= 1'b0;
endtask

// Random word whose target is neither this node nor the map target
function automatic logic [31:0] bypass_word();
    logic [31:0] w;
    w = xorshift32();
    while (w[31:24] == {MY_ROW, MY_COL} || w[31:24] == {MT_ROW, MT_COL}) begin
        w = xorshift32();
    end
    return w;
endfunction

function automatic logic [31:0] signal_word(input logic [1:0] idx, input logic st);
    logic [31:0] r;
    r = xorshift32();
    return {MY_ROW, MY_COL, 2'b00, idx, st, r[18:0]};
endfunction

task automatic wait_idle();
    int n;
    n = 0;
    repeat (4) @(negedge clk_i);
    while (!idle_o && n < 2000) begin
        @(negedge clk_i);
        n++;
    end
    checks++;
    assert (byp_q.size() == 0 && emit_q.size() == 0) else begin
        $display("Missing output: %0d bypass and %0d emitted messages never left the node",
                 byp_q.size(), emit_q.size());
        errors++;
    end
endtask

task automatic end_test(input string name, input int err_start);
    tests++;
    if (errors == err_start) $display("test %-14s OK", name);
    else $display("test %-14s FAILED with %0d errors", name, errors - err_start);
endtask

// ------------------------------
// Comparing process
// ------------------------------

always @(negedge clk_i) begin
    if (rst_n_i && ob_valid_o && ob_ready_i) begin
        ob_count++;
        checks++;
        // Map target address marks an emitted word
        if (ob_data_o[31:24] == {MT_ROW, MT_COL}) begin
            assert (emit_q.size() > 0 && ob_data_o == emit_q[0] && ob_dir_o == emit_dir_q[0])
            else begin
                $display("[FAIL] %0t emit mismatch, got %h dir %0d", $time, ob_data_o, ob_dir_o);
                errors++;
            end
            if (emit_q.size() > 0) begin
                void'(emit_q.pop_front());
                void'(emit_dir_q.pop_front());
            end
        end else begin
            assert (byp_q.size() > 0 && ob_data_o == byp_q[0] && ob_dir_o == byp_dir_q[0])
            else begin
                $display("[FAIL] %0t bypass mismatch, got %h dir %0d", $time, ob_data_o, ob_dir_o);
                errors++;
            end
            if (byp_q.size() > 0) begin
                void'(byp_q.pop_front());
                void'(byp_dir_q.pop_front());
            end
        end
    end
end

// Random outbound ready while back-pressure is on
always @(posedge clk_i) begin
    if (bp_mode) begin
        bp_word = xorshift32();
        ob_ready_i <= bp_word[4];
    end else begin
        ob_ready_i <= 1'b1;
    end
end

// Run limit
always @(posedge clk_i) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
        $display("Timeout: simulation ran past %0d cycles without finishing", CYCLE_LIMIT);
        $display("Regression failed");
        $finish;
    end
end

// ------------------------------
// Main sequence
// ------------------------------

initial begin
    int          e0, i, c0, lat;
    logic [31:0] r;
    ib_data_i  = '0;
    ib_valid_i = 1'b0;
    ob_ready_i = 1'b1;
    bp_mode    = 1'b0;
    bp_word    = '0;
    rng        = 32'd88855;
    {errors, checks, tests, ob_count, sent, cycles} = '0;
    {m_inp, m_lut, m_row, m_col, m_idx, m_mval, m_last} = '0;
    @(posedge rst_n_i);

    // Reset values
    e0 = errors;
    @(negedge clk_i);
    checks++;
    assert (!ob_valid_o && ib_ready_o) else begin
        $display("[FAIL] %0t outputs wrong after reset", $time);
        errors++;
    end
    repeat (2) @(negedge clk_i);
    checks++;
    assert (idle_o) else begin
        $display("[FAIL] %0t idle_o not high after reset", $time);
        errors++;
    end
    end_test("reset", e0);

    e0 = errors;
    for (i = 0; i < 40; i++) send_msg(bypass_word());
    wait_idle();
    end_test("bypass", e0);

    // No map loaded yet
    e0 = errors;
    c0 = ob_count;
    send_msg({MY_ROW, MY_COL, 2'b01, 16'hFFFF, 6'd0});
    for (i = 0; i < 6; i++) send_msg(signal_word(i[1:0], i[0]));
    r = xorshift32();
    send_msg({MY_ROW, MY_COL, 2'b10, MT_ROW, MT_COL, r[1:0], 12'd0});
    for (i = 0; i < 3; i++) begin
        r = xorshift32();
        send_msg({MY_ROW, MY_COL, 2'b11, r[21:0]});
    end
    wait_idle();
    checks++;
    assert (ob_count == c0) else begin
        $display("[FAIL] %0t %0d messages left with no map", $time, ob_count - c0);
        errors++;
    end
    end_test("no_map", e0);

    e0 = errors;
    r = xorshift32();
    send_msg({MY_ROW, MY_COL, 2'b01, r[15:0], 6'd0});
    for (i = 0; i < 40; i++) begin
        r = xorshift32();
        send_msg(signal_word(r[1:0], r[2]));
    end
    wait_idle();
    end_test("logic_eval", e0);

    // Mixed paths under random back-pressure
    e0 = errors;
    bp_mode = 1'b1;
    for (i = 0; i < 40; i++) begin
        r = xorshift32();
        if (r[0]) send_msg(bypass_word());
        else send_msg(signal_word(r[2:1], r[3]));
    end
    bp_mode = 1'b0;
    wait_idle();
    end_test("backpressure", e0);

    // Bypass latency first and emit latency after
    e0 = errors;
    send_msg(bypass_word());
    lat = 0;
    do begin
        @(negedge clk_i);
        lat++;
    end while (!ob_valid_o && lat < 10);
    checks++;
    assert (lat == 2) else begin
        $display("[FAIL] %0t bypass latency %0d, expected 2", $time, lat);
        errors++;
    end
    wait_idle();
    send_msg({MY_ROW, MY_COL, 2'b01, (m_inp[0] == m_last) ? 16'hAAAA : 16'h5555, 6'd0});
    wait_idle();
    send_msg(signal_word(2'd0, !m_inp[0]));
    lat = 0;
    do begin
        @(negedge clk_i);
        lat++;
    end while (!ob_valid_o && lat < 10);
    checks++;
    assert (lat == 3) else begin
        $display("[FAIL] %0t emit latency %0d, expected 3", $time, lat);
        errors++;
    end
    wait_idle();
    end_test("latency", e0);

    $display("Summary: %0d tests, %0d messages, %0d checks, %0d errors",
             tests, sent, checks, errors);
    if (errors == 0) begin
        $display("Regression passed");
    end else begin
        $display("Regression failed");
    end
    $finish;
end

endmodule : tb_nx_node

`default_nettype wire

//--- vlog.f
nx_pkg.sv
nx_msg_router.sv
nx_logic_unit.sv
nx_stream_combiner.sv
nx_node.sv
tb_clock_gen.sv
tb_nx_node.sv

//--- Makefile
# Verilator build and run for the node testbench

TOP := tb_nx_node

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
